//--- design/ids_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared widths and types of the packet buffer
////////////////////////////////////////////////////////////////////////////

package ids_pkg;

   // one bus word of packet data
   localparam int DATA_W = 64;

   // one control bit per data byte
   localparam int CTRL_W = DATA_W / 8;

   // default log2 of the buffer depth, 256 entries
   localparam int BUF_ADDR_W_DEF = 8;

   // one stored word
   // ctrl sits in the upper bits, same order as {ctrl, data} on the bus
   typedef struct packed {
      logic [CTRL_W-1:0] ctrl;
      logic [DATA_W-1:0] data;
   } pkt_word_t;

   // framing FSM states
   // idle     waiting for a word with nonzero ctrl
   // header   opening word(s) seen, waiting for the first zero ctrl
   // payload  body words, next nonzero ctrl closes the packet
   // drain    input closed, buffered packet goes downstream
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_HEADER  = 2'd1,
      ST_PAYLOAD = 2'd2,
      ST_DRAIN   = 2'd3
   } frame_state_t;

endpackage

`default_nettype wire

//--- design/pkt_buffer_ram.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// packet storage, one write port and one registered read port
////////////////////////////////////////////////////////////////////////////

module pkt_buffer_ram #(
   parameter int BUF_ADDR_W = ids_pkg::BUF_ADDR_W_DEF
) (
   input  wire                     clk,
   input  wire                     wr_en_i,
   input  wire [BUF_ADDR_W-1:0]    wr_addr_i,
   input  wire ids_pkg::pkt_word_t wr_word_i,
   input  wire [BUF_ADDR_W-1:0]    rd_addr_i,
   output ids_pkg::pkt_word_t      rd_word_o
);

   import ids_pkg::*;

   localparam int DEPTH = 1 << BUF_ADDR_W;

   // storage array, contents undefined until written
   pkt_word_t mem [0:DEPTH-1];

   // write port
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_word_i;
      end
   end

   // read port, one cycle of latency
   // address is sampled every cycle, the pointer unit qualifies the result
   always_ff @(posedge clk) begin
      rd_word_o <= mem[rd_addr_i];
   end

endmodule

`default_nettype wire

//--- design/buf_pointers.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// write, head and read pointers of the packet buffer
////////////////////////////////////////////////////////////////////////////

module buf_pointers #(
   parameter int BUF_ADDR_W = ids_pkg::BUF_ADDR_W_DEF
) (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    wr_accept_i,
   input  wire                    pkt_start_i,
   input  wire                    pkt_end_i,
   input  wire                    draining_i,
   input  wire                    out_rdy_i,
   output logic [BUF_ADDR_W-1:0]  wr_addr_o,
   output logic [BUF_ADDR_W-1:0]  rd_addr_o,
   output logic                   wr_en_o,
   output logic                   out_wr_o,
   output logic                   drain_done_o,
   output logic [BUF_ADDR_W:0]    depth_o
);

   // next free slot
   logic [BUF_ADDR_W-1:0] wr_ptr_q;
   // next slot to send downstream
   logic [BUF_ADDR_W-1:0] rd_ptr_q;
   // one past the closing word of the buffered packet
   logic [BUF_ADDR_W-1:0] head_ptr_q;
   // head points past a complete packet
   logic                  head_vld_q;
   // words held, one extra bit so a full buffer is distinct from empty
   logic [BUF_ADDR_W:0]   depth_q;
   // read issued this cycle
   logic                  rd_issue;
   // word on the RAM output is valid
   logic                  out_wr_q;

   ////////////////////////////////////////////////////////////////////////////
   // read issue and drain end
   ////////////////////////////////////////////////////////////////////////////

   // head only counts once the closing word has set it
   // the cycle after pkt_end still sees the old head
   assign rd_issue     = draining_i & head_vld_q & out_rdy_i & (rd_ptr_q != head_ptr_q);

   // all words of the packet issued
   assign drain_done_o = draining_i & head_vld_q & (rd_ptr_q == head_ptr_q);

   assign wr_en_o   = wr_accept_i;
   assign wr_addr_o = wr_ptr_q;
   assign rd_addr_o = rd_ptr_q;
   assign depth_o   = depth_q;
   assign out_wr_o  = out_wr_q;

   ////////////////////////////////////////////////////////////////////////////
   // pointer registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         head_ptr_q <= '0;
         head_vld_q <= 1'b0;
      end else begin
         if (wr_accept_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_issue) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // closing word goes to wr_ptr_q this cycle, head lands just past it
         if (pkt_end_i) begin
            head_ptr_q <= wr_ptr_q + 1'b1;
            head_vld_q <= 1'b1;
         end else if (pkt_start_i) begin
            head_vld_q <= 1'b0;
         end
      end
   end

   // occupancy, write and read can meet on the closing word cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         depth_q <= '0;
      end else begin
         case ({wr_accept_i, rd_issue})
            2'b10:   depth_q <= depth_q + 1'b1;
            2'b01:   depth_q <= depth_q - 1'b1;
            default: depth_q <= depth_q;
         endcase
      end
   end

   // RAM read latency is one cycle
   // out_wr follows the issue so valid lines up with the data
   always_ff @(posedge clk) begin
      if (reset) begin
         out_wr_q <= 1'b0;
      end else begin
         out_wr_q <= rd_issue;
      end
   end

endmodule

`default_nettype wire

//--- design/pkt_framer.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// framing FSM, finds packet boundaries on the input port
////////////////////////////////////////////////////////////////////////////

module pkt_framer #(
   parameter int BUF_ADDR_W = ids_pkg::BUF_ADDR_W_DEF
) (
   input  wire                         clk,
   input  wire                         reset,
   input  wire [ids_pkg::CTRL_W-1:0]   in_ctrl_i,
   input  wire                         in_wr_i,
   input  wire                         drain_done_i,
   input  wire [BUF_ADDR_W:0]          depth_i,
   output logic                        wr_accept_o,
   output logic                        pkt_start_o,
   output logic                        pkt_end_o,
   output logic                        draining_o,
   output logic                        in_rdy_o
);

   import ids_pkg::*;

   // input closes two entries short of full
   // this leaves room for the words already in flight
   localparam logic [BUF_ADDR_W:0] DEPTH_LIMIT =
      (BUF_ADDR_W + 1)'((1 << BUF_ADDR_W) - 2);

   frame_state_t state_q;
   frame_state_t state_d;

   // in_rdy_o as the source saw it at the last edge
   logic rdy_q;
   // word on the port that the handshake allows
   logic word_ok;
   // nonzero ctrl marks a boundary word
   logic ctrl_set;
   // decisions for the current port word
   logic accept_d;
   logic start_d;
   logic end_d;

   assign word_ok  = in_wr_i & rdy_q;
   assign ctrl_set = (in_ctrl_i != '0);

   ////////////////////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d  = state_q;
      accept_d = 1'b0;
      start_d  = 1'b0;
      end_d    = 1'b0;
      case (state_q)
         ST_IDLE: begin
            // zero ctrl here is a stray word, dropped
            if (word_ok && ctrl_set) begin
               state_d  = ST_HEADER;
               accept_d = 1'b1;
               start_d  = 1'b1;
            end
         end
         ST_HEADER: begin
            // further nonzero words stay part of the header
            if (word_ok) begin
               accept_d = 1'b1;
               if (!ctrl_set) begin
                  state_d = ST_PAYLOAD;
               end
            end
         end
         ST_PAYLOAD: begin
            if (word_ok) begin
               accept_d = 1'b1;
               // closing word, stored and then the buffer drains
               if (ctrl_set) begin
                  end_d   = 1'b1;
                  state_d = ST_DRAIN;
               end
            end
         end
         ST_DRAIN: begin
            // port is closed, wait for the last read
            if (drain_done_i) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // input ready
   ////////////////////////////////////////////////////////////////////////////

   // low on the closing word itself so the source stops at the next edge
   // stays low through the drain
   assign draining_o = (state_q == ST_DRAIN);
   assign in_rdy_o   = ~draining_o & ~end_d & (depth_i < DEPTH_LIMIT);

   ////////////////////////////////////////////////////////////////////////////
   // state and registered strobes
   ////////////////////////////////////////////////////////////////////////////

   // strobes are one cycle late, in step with the registered word in the top
   always_ff @(posedge clk) begin
      if (reset) begin
         state_q     <= ST_IDLE;
         rdy_q       <= 1'b1;
         wr_accept_o <= 1'b0;
         pkt_start_o <= 1'b0;
         pkt_end_o   <= 1'b0;
      end else begin
         state_q     <= state_d;
         rdy_q       <= in_rdy_o;
         wr_accept_o <= accept_d;
         pkt_start_o <= start_d;
         pkt_end_o   <= end_d;
      end
   end

endmodule

`default_nettype wire

//--- design/ids_top.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// store-and-forward packet buffer, top level
////////////////////////////////////////////////////////////////////////////

module ids_top #(
   parameter int BUF_ADDR_W = ids_pkg::BUF_ADDR_W_DEF
) (
   input  wire                         clk,
   input  wire                         reset,
   input  wire [ids_pkg::DATA_W-1:0]   in_data_i,
   input  wire [ids_pkg::CTRL_W-1:0]   in_ctrl_i,
   input  wire                         in_wr_i,
   output logic                        in_rdy_o,
   output logic [ids_pkg::DATA_W-1:0]  out_data_o,
   output logic [ids_pkg::CTRL_W-1:0]  out_ctrl_o,
   output logic                        out_wr_o,
   input  wire                         out_rdy_i
);

   import ids_pkg::*;

   // input register stage
   pkt_word_t             in_word_q;
   logic                  in_wr_q;

   // framer to pointer unit
   logic                  wr_accept;
   logic                  pkt_start;
   logic                  pkt_end;
   logic                  draining;
   logic                  buf_wr;

   // pointer unit back to framer
   logic                  drain_done;
   logic [BUF_ADDR_W:0]   depth;

   // RAM side
   logic                  wr_en;
   logic [BUF_ADDR_W-1:0] wr_addr;
   logic [BUF_ADDR_W-1:0] rd_addr;
   pkt_word_t             rd_word;

   ////////////////////////////////////////////////////////////////////////////
   // input register
   ////////////////////////////////////////////////////////////////////////////

   // valid bit
   always_ff @(posedge clk) begin
      if (reset) begin
         in_wr_q <= 1'b0;
      end else begin
         in_wr_q <= in_wr_i;
      end
   end

   // payload, loads only on an offered word
   always_ff @(posedge clk) begin
      if (in_wr_i) begin
         in_word_q.ctrl <= in_ctrl_i;
         in_word_q.data <= in_data_i;
      end
   end

   // registered word is written only if valid and claimed by the framer
   assign buf_wr = wr_accept & in_wr_q;

   ////////////////////////////////////////////////////////////////////////////
   // control and datapath
   ////////////////////////////////////////////////////////////////////////////

   // framer looks at the port word, one cycle ahead of the register
   pkt_framer #(
      .BUF_ADDR_W   (BUF_ADDR_W)
   ) pkt_framer_inst (
      .clk          (clk),
      .reset        (reset),
      .in_ctrl_i    (in_ctrl_i),
      .in_wr_i      (in_wr_i),
      .drain_done_i (drain_done),
      .depth_i      (depth),
      .wr_accept_o  (wr_accept),
      .pkt_start_o  (pkt_start),
      .pkt_end_o    (pkt_end),
      .draining_o   (draining),
      .in_rdy_o     (in_rdy_o)
   );

   buf_pointers #(
      .BUF_ADDR_W   (BUF_ADDR_W)
   ) buf_pointers_inst (
      .clk          (clk),
      .reset        (reset),
      .wr_accept_i  (buf_wr),
      .pkt_start_i  (pkt_start),
      .pkt_end_i    (pkt_end),
      .draining_i   (draining),
      .out_rdy_i    (out_rdy_i),
      .wr_addr_o    (wr_addr),
      .rd_addr_o    (rd_addr),
      .wr_en_o      (wr_en),
      .out_wr_o     (out_wr_o),
      .drain_done_o (drain_done),
      .depth_o      (depth)
   );

   pkt_buffer_ram #(
      .BUF_ADDR_W   (BUF_ADDR_W)
   ) pkt_buffer_ram_inst (
      .clk          (clk),
      .wr_en_i      (wr_en),
      .wr_addr_i    (wr_addr),
      .wr_word_i    (in_word_q),
      .rd_addr_i    (rd_addr),
      .rd_word_o    (rd_word)
   );

   // read word straight onto the output bus
   // qualified by out_wr_o
   assign out_ctrl_o = rd_word.ctrl;
   assign out_data_o = rd_word.data;

endmodule

`default_nettype wire

//--- verif/ids_assert.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// protocol properties of the packet buffer
////////////////////////////////////////////////////////////////////////////

module ids_assert (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        out_rdy_i,
   input  wire                        out_wr_i,
   input  wire                        in_rdy_i,
   input  wire ids_pkg::frame_state_t state_i
);

   import ids_pkg::*;

   // failed property count
   int fail_cnt = 0;

   // back-pressure holds off the read, so no word one cycle later
   no_spurious_out: assert property (@(posedge clk) disable iff (reset)
      !out_rdy_i |=> !out_wr_i)
      else begin
         fail_cnt++;
         $error("out_wr_o high after a cycle with out_rdy_i low");
      end

   // input port stays closed while words leave
   rdy_low_on_out: assert property (@(posedge clk) disable iff (reset)
      out_wr_i |-> !in_rdy_i)
      else begin
         fail_cnt++;
         $error("in_rdy_o high in a cycle with out_wr_o high");
      end

   // output words only while the framing FSM drains
   out_in_drain: assert property (@(posedge clk) disable iff (reset)
      out_wr_i |-> state_i == ST_DRAIN)
      else begin
         fail_cnt++;
         $error("out_wr_o high outside the drain state");
      end

endmodule

// framing state lives one level down
bind ids_top ids_assert ids_assert_inst (
   .clk        (clk),
   .reset      (reset),
   .out_rdy_i  (out_rdy_i),
   .out_wr_i   (out_wr_o),
   .in_rdy_i   (in_rdy_o),
   .state_i    (pkt_framer_inst.state_q)
);

`default_nettype wire

//--- verif/ids_checker.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// reference model and scoreboard on the DUT ports
////////////////////////////////////////////////////////////////////////////

module ids_checker (
   input  wire                       clk,
   input  wire                       reset,
   input  wire [ids_pkg::DATA_W-1:0] in_data_i,
   input  wire [ids_pkg::CTRL_W-1:0] in_ctrl_i,
   input  wire                       in_wr_i,
   input  wire                       in_rdy_i,
   input  wire [ids_pkg::DATA_W-1:0] out_data_i,
   input  wire [ids_pkg::CTRL_W-1:0] out_ctrl_i,
   input  wire                       out_wr_i,
   input  wire [2:0]                 test_id_i,
   input  wire                       test_end_i,
   output int                        err_cnt_o,
   output int                        chk_cnt_o
);

   import ids_pkg::*;

   // packet words the DUT still owes, oldest first
   pkt_word_t exp_q[$];
   // queued words of a closed packet
   int        closed_cnt;
   // reference framing
   // 0 outside a packet, 1 after the opening word, 2 in payload
   int        frame;
   // in_rdy_o as latched at the last edge
   logic      rdy_prev;
   // per test tallies
   int        in_cnt;
   int        out_cnt;
   int        test_err;
   pkt_word_t in_word;
   pkt_word_t exp_word;
   pkt_word_t act_word;

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd0:    return "reset";
         3'd1:    return "min_packet";
         3'd2:    return "random_packets";
         3'd3:    return "back_pressure";
         3'd4:    return "idle_words";
         default: return "unknown";
      endcase
   endfunction

   task automatic log_mismatch(input string what, input logic [71:0] exp,
                               input logic [71:0] act);
      err_cnt_o++;
      test_err++;
      $display("Fail %s: %s expected %h actual %h", test_name(test_id_i), what, exp, act);
   endtask

   task automatic raise_error(input string msg);
      err_cnt_o++;
      test_err++;
      $display("Error in test %s: %s", test_name(test_id_i), msg);
   endtask

   initial begin
      err_cnt_o  = 0;
      chk_cnt_o  = 0;
      closed_cnt = 0;
      frame      = 0;
      rdy_prev   = 1'b1;
      in_cnt     = 0;
      out_cnt    = 0;
      test_err   = 0;
   end

   // inputs change 2 ns after the rising edge, all settled here
   always @(negedge clk) begin
      if (reset) begin
         exp_q.delete();
         closed_cnt = 0;
         frame      = 0;
         rdy_prev   = 1'b1;
      end else begin
         /////////////////////////////////////////////////////////////////////
         // input side
         /////////////////////////////////////////////////////////////////////
         if (in_wr_i && rdy_prev) begin
            in_word.ctrl = in_ctrl_i;
            in_word.data = in_data_i;
            case (frame)
               0: begin
                  // zero ctrl outside a packet is dropped
                  if (in_ctrl_i != '0) begin
                     exp_q.push_back(in_word);
                     in_cnt++;
                     frame = 1;
                  end
               end
               1: begin
                  exp_q.push_back(in_word);
                  in_cnt++;
                  if (in_ctrl_i == '0) begin
                     frame = 2;
                  end
               end
               default: begin
                  exp_q.push_back(in_word);
                  in_cnt++;
                  // closing word
                  if (in_ctrl_i != '0) begin
                     frame      = 0;
                     closed_cnt = exp_q.size();
                  end
               end
            endcase
         end
         rdy_prev = in_rdy_i;

         // port closed from the closing word to the last output word
         if (closed_cnt > 0 && in_rdy_i) begin
            raise_error("in_rdy_o high while a closed packet is still in the buffer");
         end

         if (test_id_i == 3'd0) begin
            chk_cnt_o++;
            if (out_wr_i !== 1'b0) begin
               log_mismatch("out_wr_o after reset", 72'(1'b0), 72'(out_wr_i));
            end
            if (in_rdy_i !== 1'b1) begin
               log_mismatch("in_rdy_o after reset", 72'(1'b1), 72'(in_rdy_i));
            end
         end

         /////////////////////////////////////////////////////////////////////
         // output side
         /////////////////////////////////////////////////////////////////////
         if (out_wr_i) begin
            chk_cnt_o++;
            act_word = {out_ctrl_i, out_data_i};
            if (exp_q.size() == 0) begin
               raise_error($sformatf("output word %h with no packet word pending", act_word));
            end else if (closed_cnt == 0) begin
               raise_error($sformatf("output word %h before its packet was closed", act_word));
            end else begin
               exp_word = exp_q.pop_front();
               closed_cnt--;
               out_cnt++;
               if (act_word !== exp_word) begin
                  log_mismatch($sformatf("output word %0d", out_cnt), exp_word, act_word);
               end
            end
         end

         // end of test summary
         if (test_end_i) begin
            chk_cnt_o++;
            if (out_cnt != in_cnt) begin
               log_mismatch("output word count", 72'(in_cnt), 72'(out_cnt));
            end
            if (exp_q.size() != 0) begin
               raise_error($sformatf("%0d packet words never came out", exp_q.size()));
            end
            $display("test %0d %s finished with %0d words in, %0d words out, %0d errors",
                     test_id_i, test_name(test_id_i), in_cnt, out_cnt, test_err);
            in_cnt   = 0;
            out_cnt  = 0;
            test_err = 0;
         end
      end
   end

endmodule

`default_nettype wire

//--- verif/ids_tb.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// testbench top for the packet buffer
////////////////////////////////////////////////////////////////////////////

module ids_tb;

   import ids_pkg::*;

   localparam int CLK_PERIOD      = 40;
   localparam int DRIVE_DLY       = 2;
   localparam int RESET_CYCLES    = 8;
   localparam int BUF_ADDR_W      = BUF_ADDR_W_DEF;
   localparam int PKTS_PER_TEST   = 20;
   // min packet plus three random tests
   localparam int PKT_TOTAL       = 1 + 3 * PKTS_PER_TEST;
   localparam int MIN_LEN         = 3;
   localparam int MAX_LEN         = 40;
   localparam int WATCHDOG_CYCLES = PKT_TOTAL * (MAX_LEN * 4 + 20);
   localparam int NUM_TESTS       = 5;

   logic              clk = 1'b0;
   logic              reset;
   logic [DATA_W-1:0] in_data;
   logic [CTRL_W-1:0] in_ctrl;
   logic              in_wr;
   logic              in_rdy;
   logic [DATA_W-1:0] out_data;
   logic [CTRL_W-1:0] out_ctrl;
   logic              out_wr;
   logic              out_rdy;
   logic [2:0]        test_id;
   logic              test_end;
   // back-pressure on out_rdy
   logic              bp_on;
   // in_rdy_o as the DUT latched it at the last edge
   logic              rdy_seen = 1'b0;
   int                err_cnt;
   int                chk_cnt;
   int                assert_fails;
   integer            seed;

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(negedge clk) begin
      rdy_seen <= in_rdy;
   end

   ids_top #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) ids_top_inst (
      .clk        (clk),
      .reset      (reset),
      .in_data_i  (in_data),
      .in_ctrl_i  (in_ctrl),
      .in_wr_i    (in_wr),
      .in_rdy_o   (in_rdy),
      .out_data_o (out_data),
      .out_ctrl_o (out_ctrl),
      .out_wr_o   (out_wr),
      .out_rdy_i  (out_rdy)
   );

   ids_checker ids_checker_inst (
      .clk        (clk),
      .reset      (reset),
      .in_data_i  (in_data),
      .in_ctrl_i  (in_ctrl),
      .in_wr_i    (in_wr),
      .in_rdy_i   (in_rdy),
      .out_data_i (out_data),
      .out_ctrl_i (out_ctrl),
      .out_wr_i   (out_wr),
      .test_id_i  (test_id),
      .test_end_i (test_end),
      .err_cnt_o  (err_cnt),
      .chk_cnt_o  (chk_cnt)
   );

   ////////////////////////////////////////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'($unsigned($random(seed)) % $unsigned(hi - lo + 1));
   endfunction

   function automatic logic [DATA_W-1:0] rand_data();
      return {$random(seed), $random(seed)};
   endfunction

   // boundary word ctrl, never zero
   function automatic logic [CTRL_W-1:0] rand_ctrl();
      logic [CTRL_W-1:0] c;
      c = CTRL_W'($random(seed));
      if (c == '0) begin
         c = '1;
      end
      return c;
   endfunction

   // to the drive point of the next cycle
   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DLY;
      if (bp_on) begin
         out_rdy = (($random(seed) & 32'h1) != 0);
      end else begin
         out_rdy = 1'b1;
      end
   endtask

   // one word, offered once the DUT is ready
   task automatic send_word(input logic [CTRL_W-1:0] ctrl, input logic [DATA_W-1:0] data);
      while (!rdy_seen) begin
         next_cycle();
      end
      in_ctrl = ctrl;
      in_data = data;
      in_wr   = 1'b1;
      next_cycle();
      in_wr   = 1'b0;
   endtask

   // opening word, zero ctrl payload, closing word
   task automatic send_packet(input int len);
      int i;
      send_word(rand_ctrl(), rand_data());
      for (i = 1; i < len - 1; i++) begin
         send_word('0, rand_data());
      end
      send_word(rand_ctrl(), rand_data());
   endtask

   // in_rdy_o rises only after the last word has left
   task automatic wait_drained();
      while (!rdy_seen) begin
         next_cycle();
      end
   endtask

   task automatic finish_test();
      test_end = 1'b1;
      next_cycle();
      test_end = 1'b0;
      test_id  = test_id + 1'b1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      seed     = 32'hec80e59b;
      reset    = 1'b1;
      in_data  = '0;
      in_ctrl  = '0;
      in_wr    = 1'b0;
      out_rdy  = 1'b1;
      test_id  = 3'd0;
      test_end = 1'b0;
      bp_on    = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      reset = 1'b0;

      // quiet port after reset
      repeat (4) next_cycle();
      finish_test();

      send_packet(MIN_LEN);
      wait_drained();
      finish_test();

      repeat (PKTS_PER_TEST) begin
         send_packet(rand_range(MIN_LEN, MAX_LEN));
         repeat (rand_range(0, 3)) next_cycle();
      end
      wait_drained();
      finish_test();

      bp_on = 1'b1;
      repeat (PKTS_PER_TEST) begin
         send_packet(rand_range(MIN_LEN, MAX_LEN));
         repeat (rand_range(0, 3)) next_cycle();
      end
      wait_drained();
      bp_on = 1'b0;
      finish_test();

      // stray zero ctrl words ahead of each packet
      repeat (PKTS_PER_TEST) begin
         repeat (rand_range(1, 4)) send_word('0, rand_data());
         send_packet(rand_range(MIN_LEN, MAX_LEN));
      end
      wait_drained();
      finish_test();

      assert_fails = ids_top_inst.ids_assert_inst.fail_cnt;
      $display("%0d tests run, %0d checks, %0d errors, %0d assertion failures",
               NUM_TESTS, chk_cnt, err_cnt, assert_fails);
      if (err_cnt == 0 && assert_fails == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles with test %0d still running",
               WATCHDOG_CYCLES, test_id);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
design/ids_pkg.sv
design/pkt_buffer_ram.sv
design/buf_pointers.sv
design/pkt_framer.sv
design/ids_top.sv
verif/ids_assert.sv
verif/ids_checker.sv
verif/ids_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the packet buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ids_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f src.f --top-module ids_tb --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
   exit 0
else
   echo "pass message not found in $LOG"
   exit 1
fi
